//--- source/jls_params.svh
`ifndef JLS_PARAMS_SVH
`define JLS_PARAMS_SVH

// ------------------------------------------------------------
// data widths
// ------------------------------------------------------------
`define JLS_PIX_W       8    // grey pixel
`define JLS_DIM_W       14   // column index, dimension minus one
`define JLS_MIN_W       4    // smallest width-minus-one accepted
`define JLS_WORD_W      16   // output word
`define JLS_CODE_W      24   // code field, longest code is 23 bits
`define JLS_LEN_W       5    // code length field
`define JLS_BUF_W       64   // packer accumulator

// golomb-rice constants, fixed for all frames
`define JLS_K           2
`define JLS_UNARY_MAX   14   // escape at this prefix length or above

`define JLS_HDR_WORDS   13   // file header length in words
`define JLS_DRAIN_CYCLES 5   // idle cycles before flush, covers the pipeline

`endif

//--- source/jls_pkg.sv
`default_nettype none

`include "jls_params.svh"

package jls_pkg;

    typedef logic [`JLS_PIX_W-1:0]  pixel_t;    // pixel value
    typedef logic [`JLS_DIM_W-1:0]  dim_t;      // column or dimension minus one
    typedef logic [`JLS_PIX_W-1:0]  merr_t;     // mapped error 0..255
    typedef logic [`JLS_CODE_W-1:0] code_t;     // left-aligned code bits
    typedef logic [`JLS_LEN_W-1:0]  codelen_t;  // code length in bits
    typedef logic [`JLS_WORD_W-1:0] word_t;     // output stream word

    // frame control states
    typedef enum logic [2:0] {
        IDLE,    // waiting for i_sof
        HEADER,  // header words going out
        PIXELS,  // accepting pixels
        DRAIN,   // pipeline emptying
        FOOTER   // waiting for packer flush, then end marker
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/jls_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// pixel position, ctrl -> line buffer
interface pos_if;
    import jls_pkg::*;
    logic   valid;      // one pulse per accepted pixel
    pixel_t x;
    dim_t   col;
    logic   first_row;
    logic   first_col;
    modport ctrl (output valid, x, col, first_row, first_col);
    modport lb   (input  valid, x, col, first_row, first_col);
endinterface

// pixel with its neighbours, line buffer -> mapper
interface ctx_if;
    import jls_pkg::*;
    logic   valid;
    pixel_t x;
    pixel_t a;  // left
    pixel_t b;  // above
    pixel_t c;  // above-left
    modport src (output valid, x, a, b, c);
    modport dst (input  valid, x, a, b, c);
endinterface

// packed stream words plus flush handshake
interface word_if;
    import jls_pkg::*;
    logic  valid;
    word_t data;
    logic  flush;       // ctrl pulse, end of frame
    logic  flush_done;  // packer pulse, everything sent
    modport packer (output valid, data, flush_done, input flush);
    modport ctrl   (input  valid, data, flush_done, output flush);
endinterface

`default_nettype wire

//--- source/encoder_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "jls_params.svh"

module encoder_ctrl (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   i_sof,
    input  wire jls_pkg::dim_t    i_w,
    input  wire jls_pkg::dim_t    i_h,
    input  wire                   i_e,
    input  wire jls_pkg::pixel_t  i_x,
    pos_if.ctrl                   pos,
    word_if.ctrl                  word,
    output logic                  o_e,
    output jls_pkg::word_t        o_data,
    output logic                  o_last
);
    import jls_pkg::*;

    ctrl_state_t state;
    dim_t        w_lim;      // clamped width minus one
    dim_t        h_lim;
    dim_t        col;
    dim_t        row;
    logic [3:0]  hdr_idx;
    logic [2:0]  drain_cnt;
    word_t       hdr_word;

    // ------------------------------------------------------------
    // header word table
    // ------------------------------------------------------------
    always_comb begin
        case (hdr_idx)
            4'd0:    hdr_word = 16'hFFD8;  // SOI
            4'd1:    hdr_word = 16'h00FF;
            4'd2:    hdr_word = 16'hF700;  // SOF55 marker
            4'd3:    hdr_word = 16'h0B08;  // length, 8 bit precision
            4'd4:    hdr_word = word_t'(h_lim) + word_t'(1);
            4'd5:    hdr_word = word_t'(w_lim) + word_t'(1);
            4'd6:    hdr_word = 16'h0101;  // one component
            4'd7:    hdr_word = 16'h1100;
            4'd8:    hdr_word = 16'hFFDA;  // SOS
            4'd9:    hdr_word = 16'h0008;
            4'd10:   hdr_word = 16'h0101;
            default: hdr_word = 16'h0000;  // near = 0, ilv = 0
        endcase
    end

    // ------------------------------------------------------------
    // frame fsm, position counters, output mux
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            hdr_idx    <= '0;
            drain_cnt  <= '0;
            col        <= '0;
            row        <= '0;
            pos.valid  <= 1'b0;
            word.flush <= 1'b0;
            o_e        <= 1'b0;
            o_last     <= 1'b0;
        end else begin
            pos.valid  <= 1'b0;
            word.flush <= 1'b0;
            o_last     <= 1'b0;
            o_e        <= word.valid;  // packer words, one cycle late
            o_data     <= word.data;
            case (state)
                IDLE: if (i_sof) begin
                    w_lim   <= (i_w < dim_t'(`JLS_MIN_W)) ? dim_t'(`JLS_MIN_W) : i_w;
                    h_lim   <= i_h;
                    col     <= '0;
                    row     <= '0;
                    o_e     <= 1'b1;
                    o_data  <= hdr_word;  // idx 0, constant SOI
                    hdr_idx <= 4'd1;
                    state   <= HEADER;
                end
                HEADER: begin
                    o_e     <= 1'b1;
                    o_data  <= hdr_word;
                    hdr_idx <= hdr_idx + 4'd1;
                    if (hdr_idx == 4'(`JLS_HDR_WORDS - 1)) begin
                        hdr_idx <= '0;
                        state   <= PIXELS;
                    end
                end
                PIXELS: if (i_e) begin
                    pos.valid     <= 1'b1;
                    pos.x         <= i_x;
                    pos.col       <= col;
                    pos.first_row <= (row == '0);
                    pos.first_col <= (col == '0);
                    if (col == w_lim) begin  // end of line
                        col <= '0;
                        if (row == h_lim) begin
                            drain_cnt <= '0;
                            state     <= DRAIN;
                        end else begin
                            row <= row + dim_t'(1);
                        end
                    end else begin
                        col <= col + dim_t'(1);
                    end
                end
                DRAIN: begin
                    drain_cnt <= drain_cnt + 3'd1;
                    if (drain_cnt == 3'(`JLS_DRAIN_CYCLES - 1)) begin
                        word.flush <= 1'b1;
                        state      <= FOOTER;
                    end
                end
                FOOTER: if (word.flush_done) begin
                    o_e    <= 1'b1;
                    o_data <= 16'hFFD9;  // EOI
                    o_last <= 1'b1;
                    state  <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/context_linebuf.sv
`timescale 1ns/1ps
`default_nettype none

`include "jls_params.svh"

module context_linebuf (
    input  wire  clk,
    input  wire  reset,
    pos_if.lb    pos,
    ctx_if.src   ctx
);
    import jls_pkg::*;

    pixel_t line_mem [0:(1 << `JLS_DIM_W)-1];  // previous row, by column

    // stage 1 regs
    logic   s1_valid;
    pixel_t s1_x;
    dim_t   s1_col;
    logic   s1_first_row;
    logic   s1_first_col;
    pixel_t above_rd;      // pixel above, read ahead

    pixel_t left_q;        // last pixel of the row
    pixel_t above_left_q;  // above of last pixel
    pixel_t a_n;
    pixel_t b_n;
    pixel_t c_n;

    // ------------------------------------------------------------
    // stage 1: line memory read
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) s1_valid <= 1'b0;
        else       s1_valid <= pos.valid;
        above_rd     <= line_mem[pos.col];
        s1_x         <= pos.x;
        s1_col       <= pos.col;
        s1_first_row <= pos.first_row;
        s1_first_col <= pos.first_col;
    end

    // edge rules
    always_comb begin
        b_n = s1_first_row ? '0 : above_rd;  // nothing above in row 0
        if (s1_first_col) begin
            a_n = b_n;
            c_n = b_n;
        end else begin
            a_n = left_q;
            c_n = s1_first_row ? '0 : above_left_q;
        end
    end

    // ------------------------------------------------------------
    // stage 2: neighbours out, write back
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) ctx.valid <= 1'b0;
        else       ctx.valid <= s1_valid;
        if (s1_valid) begin
            ctx.x        <= s1_x;
            ctx.a        <= a_n;
            ctx.b        <= b_n;
            ctx.c        <= c_n;
            left_q       <= s1_x;
            above_left_q <= b_n;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) line_mem[s1_col] <= s1_x;  // after its read as above
    end

endmodule

`default_nettype wire

//--- source/residual_mapper.sv
`timescale 1ns/1ps
`default_nettype none

`include "jls_params.svh"

module residual_mapper (
    input  wire              clk,
    input  wire              reset,
    ctx_if.dst               ctx,
    output logic             o_valid,
    output jls_pkg::merr_t   o_merr
);
    import jls_pkg::*;

    pixel_t nb_max;
    pixel_t nb_min;
    pixel_t px;                            // prediction
    logic signed [`JLS_PIX_W-1:0] err;     // error mod 256, -128..127
    merr_t merr;

    // ------------------------------------------------------------
    // median edge predictor
    // ------------------------------------------------------------
    always_comb begin
        nb_max = (ctx.a > ctx.b) ? ctx.a : ctx.b;
        nb_min = (ctx.a > ctx.b) ? ctx.b : ctx.a;
        if (ctx.c >= nb_max)
            px = nb_min;                   // edge above or left
        else if (ctx.c <= nb_min)
            px = nb_max;
        else
            px = ctx.a + ctx.b - ctx.c;    // lies between min and max, no wrap
    end

    // 8-bit subtract wraps, read back as signed
    assign err = ctx.x - px;

    // non-negative map: 2e or -2e-1
    // -2e-1 is just the inverse of 2e
    assign merr = err[`JLS_PIX_W-1] ? ~{err[`JLS_PIX_W-2:0], 1'b0}
                                    :  {err[`JLS_PIX_W-2:0], 1'b0};

    always_ff @(posedge clk) begin
        if (reset) o_valid <= 1'b0;
        else       o_valid <= ctx.valid;
        o_merr <= merr;
    end

endmodule

`default_nettype wire

//--- source/golomb_coder.sv
`timescale 1ns/1ps
`default_nettype none

`include "jls_params.svh"

module golomb_coder (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  i_valid,
    input  wire jls_pkg::merr_t  i_merr,
    output logic                 o_valid,
    output jls_pkg::code_t       o_code,
    output jls_pkg::codelen_t    o_len
);
    import jls_pkg::*;

    merr_t    q;     // unary prefix length
    codelen_t len;
    code_t    code;

    always_comb begin
        q = i_merr >> `JLS_K;
        if (q < merr_t'(`JLS_UNARY_MAX)) begin
            // q zeros, stop bit, k low bits
            len  = codelen_t'(q) + codelen_t'(`JLS_K + 1);
            code = code_t'({1'b1, i_merr[`JLS_K-1:0]}) << (`JLS_CODE_W - len);
        end else begin
            // escape: max zeros, stop bit, merr-1 in full
            len  = codelen_t'(`JLS_UNARY_MAX + 1 + `JLS_PIX_W);
            code = code_t'({1'b1, i_merr - merr_t'(1)}) << (`JLS_CODE_W - len);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) o_valid <= 1'b0;
        else       o_valid <= i_valid;
        o_code <= code;
        o_len  <= len;
    end

endmodule

`default_nettype wire

//--- source/bit_packer.sv
`timescale 1ns/1ps
`default_nettype none

`include "jls_params.svh"

module bit_packer (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     i_valid,
    input  wire jls_pkg::code_t     i_code,
    input  wire jls_pkg::codelen_t  i_len,
    word_if.packer                  word
);
    import jls_pkg::*;

    logic [`JLS_BUF_W-1:0] acc;     // msb first, zeros below cnt
    logic [6:0]            cnt;     // valid bits in acc
    logic                  flush_pend;
    logic [`JLS_BUF_W-1:0] acc_s;
    logic [6:0]            cnt_s;
    logic                  emit;
    logic                  pad;     // last partial word
    logic [7:0]            hi;
    logic [7:0]            lo;

    // ------------------------------------------------------------
    // word extraction with marker stuffing, then append
    // ------------------------------------------------------------
    always_comb begin
        emit  = (cnt >= 7'd16) || (flush_pend && cnt != '0);
        pad   = (cnt < 7'd16);
        acc_s = acc;
        cnt_s = cnt;
        hi    = acc_s[`JLS_BUF_W-1 -: 8];
        acc_s = {acc_s[`JLS_BUF_W-9:0], 8'h00};
        cnt_s = cnt_s - 7'd8;
        if (hi == 8'hFF) begin  // zero bit forced into next msb
            acc_s = {1'b0, acc_s[`JLS_BUF_W-1:1]};
            cnt_s = cnt_s + 7'd1;
        end
        lo    = acc_s[`JLS_BUF_W-1 -: 8];
        acc_s = {acc_s[`JLS_BUF_W-9:0], 8'h00};
        cnt_s = cnt_s - 7'd8;
        if (lo == 8'hFF) begin  // carries into the next word
            acc_s = {1'b0, acc_s[`JLS_BUF_W-1:1]};
            cnt_s = cnt_s + 7'd1;
        end
        if (!emit) begin
            acc_s = acc;
            cnt_s = cnt;
        end else if (pad) begin
            acc_s = '0;
            cnt_s = '0;
        end
        if (i_valid) begin
            acc_s = acc_s | ({i_code, {(`JLS_BUF_W-`JLS_CODE_W){1'b0}}} >> cnt_s);
            cnt_s = cnt_s + {2'b00, i_len};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc             <= '0;
            cnt             <= '0;
            flush_pend      <= 1'b0;
            word.valid      <= 1'b0;
            word.flush_done <= 1'b0;
        end else begin
            acc             <= acc_s;
            cnt             <= cnt_s;
            word.valid      <= emit;
            word.flush_done <= flush_pend && !emit;  // cnt is zero here
            if (word.flush)
                flush_pend <= 1'b1;
            else if (!emit)
                flush_pend <= 1'b0;
        end
        if (emit) word.data <= {hi, lo};
    end

endmodule

`default_nettype wire

//--- source/jls_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module jls_encoder (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   i_sof,   // frame start
    input  wire jls_pkg::dim_t    i_w,     // width minus one
    input  wire jls_pkg::dim_t    i_h,     // height minus one
    input  wire                   i_e,     // pixel strobe
    input  wire jls_pkg::pixel_t  i_x,
    output wire                   o_e,
    output wire jls_pkg::word_t   o_data,
    output wire                   o_last   // footer word
);
    import jls_pkg::*;

    pos_if  pos_bus ();
    ctx_if  ctx_bus ();
    word_if word_bus ();

    logic     map_valid;
    merr_t    map_merr;
    logic     code_valid;
    code_t    code;
    codelen_t code_len;

    // ------------------------------------------------------------
    // pipeline: ctrl -> linebuf -> mapper -> coder -> packer
    // ------------------------------------------------------------
    encoder_ctrl u_ctrl (
        .clk (clk), .reset (reset),
        .i_sof (i_sof), .i_w (i_w), .i_h (i_h), .i_e (i_e), .i_x (i_x),
        .pos (pos_bus.ctrl), .word (word_bus.ctrl),
        .o_e (o_e), .o_data (o_data), .o_last (o_last)
    );

    context_linebuf u_linebuf (
        .clk (clk), .reset (reset), .pos (pos_bus.lb), .ctx (ctx_bus.src)
    );

    residual_mapper u_mapper (
        .clk (clk), .reset (reset), .ctx (ctx_bus.dst),
        .o_valid (map_valid), .o_merr (map_merr)
    );

    golomb_coder u_coder (
        .clk (clk), .reset (reset), .i_valid (map_valid), .i_merr (map_merr),
        .o_valid (code_valid), .o_code (code), .o_len (code_len)
    );

    bit_packer u_packer (
        .clk (clk), .reset (reset),
        .i_valid (code_valid), .i_code (code), .i_len (code_len),
        .word (word_bus.packer)
    );

endmodule

`default_nettype wire

//--- testbench/jls_ref_model.svh
`ifndef JLS_REF_MODEL_SVH
`define JLS_REF_MODEL_SVH

// expected stream model, included inside tb_jls_encoder
bit          bits_q[$];    // code bits waiting to be packed, msb first
logic [15:0] exp_q[$];     // expected o_data words of one frame

// fixed header, words 4 and 5 replaced by height and width
localparam logic [15:0] hdr_fixed [0:12] = '{
    16'hFFD8, 16'h00FF, 16'hF700, 16'h0B08, 16'h0000, 16'h0000, 16'h0101,
    16'h1100, 16'hFFDA, 16'h0008, 16'h0101, 16'h0000, 16'h0000
};

// ------------------------------------------------------------
// prediction, error mapping, golomb code
// ------------------------------------------------------------
function automatic logic [7:0] med_predict(input logic [7:0] a, input logic [7:0] b,
                                           input logic [7:0] c);
    logic [7:0] mx;
    logic [7:0] mn;
    mx = (a > b) ? a : b;
    mn = (a > b) ? b : a;
    if (c >= mx) return mn;      // edge
    if (c <= mn) return mx;
    return a + b - c;            // smooth area
endfunction

function automatic logic [7:0] map_error(input logic [7:0] x, input logic [7:0] px);
    int e;
    e = int'(x) - int'(px);
    if (e > 127) e = e - 256;    // fold into -128..127
    if (e < -128) e = e + 256;
    return (e >= 0) ? 8'(2 * e) : 8'(-2 * e - 1);
endfunction

function automatic void push_code(input logic [7:0] merr);
    int q;
    int i;
    logic [7:0] rem;
    q = int'(merr) >> `JLS_K;
    if (q < `JLS_UNARY_MAX) begin
        repeat (q) bits_q.push_back(1'b0);    // unary prefix
        bits_q.push_back(1'b1);
        for (i = `JLS_K - 1; i >= 0; i--) bits_q.push_back(merr[i]);
    end else begin
        repeat (`JLS_UNARY_MAX) bits_q.push_back(1'b0);
        bits_q.push_back(1'b1);
        rem = merr - 8'd1;                     // escape payload
        for (i = 7; i >= 0; i--) bits_q.push_back(rem[i]);
    end
endfunction

// ------------------------------------------------------------
// byte extraction with marker stuffing
// ------------------------------------------------------------
function automatic logic [7:0] pop_byte();
    logic [7:0] v;
    int i;
    v = 8'h00;
    for (i = 7; i >= 0; i--) begin
        if (bits_q.size() > 0) v[i] = bits_q.pop_front();  // zeros once empty
    end
    if (v == 8'hFF) bits_q.push_front(1'b0);  // next byte msb forced low
    return v;
endfunction

function automatic void build_expected(input int w, input int h);
    int r;
    int cl;
    int idx;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    logic [7:0] hi;
    logic [7:0] lo;
    exp_q.delete();
    bits_q.delete();
    for (idx = 0; idx < `JLS_HDR_WORDS; idx++) begin
        case (idx)
            4:       exp_q.push_back(16'(h));
            5:       exp_q.push_back(16'(w));
            default: exp_q.push_back(hdr_fixed[idx]);
        endcase
    end
    for (r = 0; r < h; r++) begin
        for (cl = 0; cl < w; cl++) begin
            idx = r * w + cl;
            b = (r == 0) ? 8'h00 : pix_q[idx - w];        // nothing above row 0
            if (cl == 0) begin
                a = b;
                c = b;
            end else begin
                a = pix_q[idx - 1];
                c = (r == 0) ? 8'h00 : pix_q[idx - w - 1];
            end
            push_code(map_error(pix_q[idx], med_predict(a, b, c)));
        end
    end
    while (bits_q.size() >= 16) begin
        hi = pop_byte();
        lo = pop_byte();
        exp_q.push_back({hi, lo});
    end
    if (bits_q.size() > 0) begin  // zero padded flush word
        hi = pop_byte();
        lo = pop_byte();
        exp_q.push_back({hi, lo});
        bits_q.delete();            // stuffed zero after the last byte is dropped
    end
    exp_q.push_back(16'hFFD9);
endfunction

`endif

//--- testbench/tb_jls_encoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "jls_params.svh"

module tb_jls_encoder;
    import jls_pkg::*;

    logic   clk;
    logic   reset;
    logic   i_sof;
    dim_t   i_w;
    dim_t   i_h;
    logic   i_e;
    pixel_t i_x;
    logic   o_e;
    word_t  o_data;
    logic   o_last;

    int          seed;
    int          errors;
    int          checks;
    int          tests;
    logic [7:0]  pix_q[$];    // frame pixels, raster order
    logic [15:0] got_q[$];    // captured words
    bit          last_q[$];   // o_last per captured word

    `include "jls_ref_model.svh"

    jls_encoder DUT (
        .clk    (clk),
        .reset  (reset),
        .i_sof  (i_sof),
        .i_w    (i_w),
        .i_h    (i_h),
        .i_e    (i_e),
        .i_x    (i_x),
        .o_e    (o_e),
        .o_data (o_data),
        .o_last (o_last)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // outputs settle after posedge, sampled on negedge
    always @(negedge clk) begin
        if (o_e) begin
            got_q.push_back(o_data);
            last_q.push_back(o_last);
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    function automatic pixel_t make_pixel(input int mode, input int n, input int w,
                                          input int level);
        int r;
        r = $random(seed);
        case (mode)
            1: return pixel_t'(level);                 // flat frame
            2: begin
                if (n < w) return pixel_t'(200 - 2 * n);  // descending ramp gives runs of ones
                return r[8] ? {4'hF, r[3:0]} : {4'h0, r[3:0]};  // large jumps
            end
            default: return pixel_t'(r);
        endcase
    endfunction

    task automatic wait_last();
        int cycles;
        cycles = 0;
        while (o_last !== 1'b1 && cycles < 400) begin
            @(negedge clk);
            cycles++;
        end
        checks++;
        assert (o_last === 1'b1) else begin
            $display("timeout waiting for o_last after the last pixel");
            errors++;
        end
        @(negedge clk);  // footer word captured by now
    endtask

    task automatic run_frame(input int w_m1, input int h_m1, input int mode, input int level);
        int w;
        int h;
        int n;
        w = (w_m1 < `JLS_MIN_W) ? `JLS_MIN_W + 1 : w_m1 + 1;  // width clamp
        h = h_m1 + 1;
        pix_q.delete();
        for (n = 0; n < w * h; n++) pix_q.push_back(make_pixel(mode, n, w, level));
        got_q.delete();
        last_q.delete();
        @(negedge clk);
        i_sof = 1'b1;
        i_w   = dim_t'(w_m1);
        i_h   = dim_t'(h_m1);
        @(negedge clk);
        i_sof = 1'b0;
        repeat (16) @(negedge clk);  // header time
        for (n = 0; n < w * h; n++) begin
            i_e = 1'b1;
            i_x = pix_q[n];
            @(negedge clk);
            i_e = 1'b0;                 // idle cycle between pixels
            @(negedge clk);
        end
        wait_last();
        build_expected(w, h);
    endtask

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    task automatic compare_words(input int limit);
        int i;
        int n;
        checks++;
        assert (got_q.size() == exp_q.size()) else begin
            $display("word count wrong, got %0d expected %0d", got_q.size(), exp_q.size());
            errors++;
        end
        n = (limit < got_q.size()) ? limit : got_q.size();
        if (n > exp_q.size()) n = exp_q.size();
        for (i = 0; i < n; i++) begin
            checks++;
            assert (got_q[i] === exp_q[i]) else begin
                $display("mismatch o_data word %0d got 0x%04h expected 0x%04h",
                         i, got_q[i], exp_q[i]);
                errors++;
            end
        end
    endtask

    task automatic check_footer();
        int i;
        int n_last;
        logic [15:0] last_w;
        bit last_f;
        n_last = 0;
        for (i = 0; i < last_q.size(); i++) n_last += int'(last_q[i]);
        last_w = (got_q.size() > 0) ? got_q[got_q.size() - 1] : 16'h0000;
        last_f = (last_q.size() > 0) ? last_q[last_q.size() - 1] : 1'b0;
        checks++;
        assert (last_w === 16'hFFD9) else begin
            $display("mismatch o_data last word got 0x%04h expected 0xffd9", last_w);
            errors++;
        end
        checks++;
        assert (last_f && n_last == 1) else begin
            $display("o_last was high on %0d words, expected only on the last one", n_last);
            errors++;
        end
    endtask

    task automatic scan_stuffing();
        int i;
        int j;
        int ff_seen;
        bit prev_ff;
        logic [7:0] bt;
        ff_seen = 0;
        prev_ff = 1'b0;
        for (i = `JLS_HDR_WORDS; i < got_q.size() - 1; i++) begin  // coded words only
            for (j = 1; j >= 0; j--) begin
                bt = got_q[i][j * 8 +: 8];
                if (prev_ff) begin
                    checks++;
                    assert (bt[7] == 1'b0) else begin
                        $display("mismatch o_data byte after 0xff in word %0d got 0x%02h", i, bt);
                        errors++;
                    end
                end
                prev_ff = (bt == 8'hFF);
                if (prev_ff) ff_seen++;
            end
        end
        checks++;
        assert (ff_seen > 0) else begin
            $display("no 0xff byte in the coded words, stuffing was not exercised");
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before)
            $display("test %0d %s ... ok", tests, name);
        else
            $display("test %0d %s ... %0d errors", tests, name, errors - errs_before);
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin : main
        int e0;
        seed   = 32'hd970;
        errors = 0;
        checks = 0;
        tests  = 0;
        reset  = 1'b1;
        i_sof  = 1'b0;
        i_w    = '0;
        i_h    = '0;
        i_e    = 1'b0;
        i_x    = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        e0 = errors;
        repeat (20) begin
            @(negedge clk);
            checks++;
            assert (o_e === 1'b0 && o_last === 1'b0) else begin
                $display("mismatch o_e/o_last while idle got 0x%0h/0x%0h expected 0x0/0x0",
                         o_e, o_last);
                errors++;
            end
        end
        report_test("idle after reset", e0);

        e0 = errors;
        run_frame(5, 2, 0, 0);                  // 6 by 3
        compare_words(`JLS_HDR_WORDS);
        report_test("header of 6x3 frame", e0);

        e0 = errors;
        run_frame(6, 3, 1, 8'h80);              // flat 7 by 4
        compare_words(exp_q.size());
        check_footer();
        report_test("flat frame", e0);

        e0 = errors;
        run_frame(8, 4, 2, 0);                  // 9 by 5 with jumps
        compare_words(exp_q.size());
        scan_stuffing();
        check_footer();
        report_test("random 9x5 frame with jumps", e0);

        e0 = errors;
        run_frame(15, 1, 0, 0);                 // 16 by 2
        compare_words(exp_q.size());
        check_footer();
        report_test("footer and o_last", e0);

        e0 = errors;
        run_frame(2, 2, 0, 0);                  // narrow, coded as 5 wide
        checks++;
        assert (got_q.size() > 5 && got_q[5] === 16'h0005) else begin
            $display("mismatch o_data width word got 0x%04h expected 0x0005",
                     (got_q.size() > 5) ? got_q[5] : 16'h0000);
            errors++;
        end
        compare_words(exp_q.size());
        check_footer();
        run_frame(5, 3, 0, 0);                  // back to back, fresh context
        compare_words(exp_q.size());
        check_footer();
        report_test("width clamp and second frame", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+source
+incdir+testbench
source/jls_pkg.sv
source/jls_ifs.sv
source/encoder_ctrl.sv
source/context_linebuf.sv
source/residual_mapper.sv
source/golomb_coder.sv
source/bit_packer.sv
source/jls_encoder.sv
testbench/tb_jls_encoder.sv

//--- Makefile
# Verilator flow for the jls encoder
TOP       ?= tb_jls_encoder
SEED      ?= 0
LOG       ?= sim.log
VERILATOR ?= verilator
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
